// File: hw/flash_tester_macros.svh
`ifndef FLASH_TESTER_MACROS_SVH
`define FLASH_TESTER_MACROS_SVH

////////////////////////////////////////////////////////////
// Flash geometry
////////////////////////////////////////////////////////////

`define FLASH_ADDR_W        23      // Word address bits
`define FLASH_DATA_W        16      // Word data bits
`define FLASH_BLOCK_SIZE    65536   // Words per erase block

// Init erases only the first blocks of the device
`define FLASH_ERASE_BLOCKS  10

// Writing here completes but raises the write error
`define FLASH_LAST_ADDRESS  ({`FLASH_ADDR_W{1'b1}})

`endif

// File: hw/flash_cmd_pkg.sv
package flash_cmd_pkg;

   // Operation codes towards the flash interface
   typedef enum logic [1:0]
   {
      FLASHOP_IDLE  = 2'b00,
      FLASHOP_READ  = 2'b01,
      FLASHOP_WRITE = 2'b10
   } flash_op_t;

   // Command words written to the device
   typedef enum logic [15:0]
   {
      CMD_READ_ID     = 16'h0090,
      CMD_READ_ARRAY  = 16'h00FF,
      CMD_CLEAR_LOCKS = 16'h0060,
      CMD_CONFIRM     = 16'h00D0,   // Second cycle of lock clear and erase
      CMD_ERASE_BLOCK = 16'h0020,
      CMD_WRITE_SETUP = 16'h0040
   } flash_cmd_t;

   // Identifier words returned in read ID mode
   localparam logic [15:0] FLASH_MANUFACTURER_ID = 16'h0089;   // Manufacturer code
   localparam logic [15:0] FLASH_SIZE_ID         = 16'h0018;   // 128 Mbit

endpackage

// File: hw/tester_pkg.sv
package tester_pkg;

   typedef enum logic [1:0]
   {
      MODE_IDLE  = 2'd0,
      MODE_INIT  = 2'd1,
      MODE_WRITE = 2'd2,
      MODE_READ  = 2'd3
   } host_mode_t;

   // Phase codes first, then error codes
   typedef enum logic [3:0]
   {
      STATUS_RESET             = 4'h0,
      STATUS_READ_ID           = 4'h1,
      STATUS_CLEAR_LOCKS       = 4'h2,
      STATUS_ERASING           = 4'h3,
      STATUS_WRITING           = 4'h4,
      STATUS_READING           = 4'h5,
      STATUS_SUCCESS           = 4'h6,
      STATUS_BAD_MANUFACTURER  = 4'h7,
      STATUS_BAD_SIZE          = 4'h8,
      STATUS_LOCK_BIT_ERROR    = 4'h9,
      STATUS_ERASE_BLOCK_ERROR = 4'hA,
      STATUS_WRITE_ERROR       = 4'hB
   } tester_status_t;

   typedef enum logic [3:0]
   {
      ES_IDLE, ES_READ_MFR, ES_CHECK_MFR, ES_CHECK_SIZE, ES_LOCK_CONFIRM,
      ES_ERASE_CMD, ES_ERASE_CONFIRM, ES_POLL_RD, ES_POLL_CHK
   } erase_state_t;

   typedef enum logic [2:0]
   {
      RW_IDLE, RW_WRITE_DATA, RW_POLL_RD, RW_POLL_CHK, RW_READ, RW_CAPTURE
   } rw_state_t;

endpackage

// File: hw/flash_op_port.sv
`include "flash_tester_macros.svh"

module flash_op_port
(
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        fbusy,
   input  logic                        erase_req,
   input  logic                        rw_req,
   input  flash_cmd_pkg::flash_op_t    erase_op,
   input  flash_cmd_pkg::flash_op_t    rw_op,
   input  logic [`FLASH_ADDR_W-1:0]    erase_addr,
   input  logic [`FLASH_ADDR_W-1:0]    rw_addr,
   input  logic [`FLASH_DATA_W-1:0]    erase_data,
   input  logic [`FLASH_DATA_W-1:0]    rw_data,
   output flash_cmd_pkg::flash_op_t    fop,
   output logic [`FLASH_ADDR_W-1:0]    faddress,
   output logic [`FLASH_DATA_W-1:0]    fwdata,
   output logic                        step
);
   import flash_cmd_pkg::*;

   logic load;

   // Flash free and no operation in flight
   assign step = !fbusy && (fop == FLASHOP_IDLE);
   assign load = step && (erase_req || rw_req);

   always_ff @(posedge clock)
   begin
      if (reset)
         fop <= FLASHOP_IDLE;
      else if (load)
         fop <= erase_req ? erase_op : rw_op;
      else
         fop <= FLASHOP_IDLE;   // Single cycle strobe
   end

   always_ff @(posedge clock)
   begin
      if (load)
      begin
         faddress <= erase_req ? erase_addr : rw_addr;
         fwdata   <= erase_req ? erase_data : rw_data;
      end
   end

endmodule

// File: hw/flash_erase_seq.sv
`include "flash_tester_macros.svh"

module flash_erase_seq
(
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        step,
   input  logic                        start,
   input  logic [`FLASH_DATA_W-1:0]    frdata,
   output logic                        req,
   output flash_cmd_pkg::flash_op_t    req_op,
   output logic [`FLASH_ADDR_W-1:0]    req_addr,
   output logic [`FLASH_DATA_W-1:0]    req_data,
   output logic                        done,
   output logic                        err,
   output logic                        erase_done,
   output logic                        phase_valid,
   output tester_pkg::tester_status_t  err_code,
   output tester_pkg::tester_status_t  phase_code
);
   import flash_cmd_pkg::*;
   import tester_pkg::*;

   localparam logic [`FLASH_ADDR_W-1:0] BLOCK_STEP = `FLASH_BLOCK_SIZE;
   localparam logic [`FLASH_ADDR_W-1:0] LAST_BLOCK =
      (`FLASH_ERASE_BLOCKS - 1) * `FLASH_BLOCK_SIZE;

   erase_state_t state;
   erase_state_t next_state;
   logic [`FLASH_ADDR_W-1:0] block_addr;
   logic erasing;   // Current poll belongs to a block erase
   logic sr_ready;
   logic sr_error;

   assign sr_ready   = frdata[7];
   assign sr_error   = |frdata[6:1];
   assign erase_done = done;

   always_comb
   begin
      req         = 1'b0;
      req_op      = FLASHOP_IDLE;
      req_addr    = block_addr;   // Zero until the erase phase
      req_data    = CMD_CONFIRM;
      done        = 1'b0;
      err         = 1'b0;
      err_code    = STATUS_RESET;
      phase_valid = 1'b0;
      phase_code  = STATUS_READ_ID;
      next_state  = state;
      if (step)
      begin
         case (state)
            ES_IDLE:
               if (start)
               begin
                  req         = 1'b1;
                  req_op      = FLASHOP_WRITE;
                  req_data    = CMD_READ_ID;
                  phase_valid = 1'b1;
                  next_state  = ES_READ_MFR;
               end
            ES_READ_MFR:
            begin
               req        = 1'b1;
               req_op     = FLASHOP_READ;
               next_state = ES_CHECK_MFR;
            end
            ES_CHECK_MFR:
               if (frdata != FLASH_MANUFACTURER_ID)
               begin
                  err        = 1'b1;
                  err_code   = STATUS_BAD_MANUFACTURER;
                  next_state = ES_IDLE;
               end
               else
               begin
                  req        = 1'b1;
                  req_op     = FLASHOP_READ;
                  req_addr   = `FLASH_ADDR_W'd1;   // Size code word
                  next_state = ES_CHECK_SIZE;
               end
            ES_CHECK_SIZE:
               if (frdata != FLASH_SIZE_ID)
               begin
                  err        = 1'b1;
                  err_code   = STATUS_BAD_SIZE;
                  next_state = ES_IDLE;
               end
               else
               begin
                  req         = 1'b1;
                  req_op      = FLASHOP_WRITE;
                  req_data    = CMD_CLEAR_LOCKS;
                  phase_valid = 1'b1;
                  phase_code  = STATUS_CLEAR_LOCKS;
                  next_state  = ES_LOCK_CONFIRM;
               end
            ES_ERASE_CMD:
            begin
               req         = 1'b1;
               req_op      = FLASHOP_WRITE;
               req_data    = CMD_ERASE_BLOCK;
               phase_valid = 1'b1;
               phase_code  = STATUS_ERASING;
               next_state  = ES_ERASE_CONFIRM;
            end
            ES_LOCK_CONFIRM, ES_ERASE_CONFIRM:
            begin
               req        = 1'b1;
               req_op     = FLASHOP_WRITE;
               next_state = ES_POLL_RD;
            end
            ES_POLL_RD:
            begin
               req        = 1'b1;
               req_op     = FLASHOP_READ;
               next_state = ES_POLL_CHK;
            end
            ES_POLL_CHK:
               if (!sr_ready)
               begin
                  req    = 1'b1;   // Device still busy, read status again
                  req_op = FLASHOP_READ;
               end
               else if (sr_error)
               begin
                  err        = 1'b1;
                  err_code   = erasing ? STATUS_ERASE_BLOCK_ERROR : STATUS_LOCK_BIT_ERROR;
                  next_state = ES_IDLE;
               end
               else if (erasing && (block_addr == LAST_BLOCK))
               begin
                  done       = 1'b1;
                  next_state = ES_IDLE;
               end
               else
                  next_state = ES_ERASE_CMD;
            default:
               next_state = ES_IDLE;
         endcase
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state      <= ES_IDLE;
         block_addr <= '0;
         erasing    <= 1'b0;
      end
      else
      begin
         state <= next_state;
         if (start)
         begin
            block_addr <= '0;
            erasing    <= 1'b0;
         end
         if (state == ES_ERASE_CMD)
            erasing <= 1'b1;
         if ((state == ES_POLL_CHK) && (next_state == ES_ERASE_CMD) && erasing)
            block_addr <= block_addr + BLOCK_STEP;   // Next block
      end
   end

endmodule

// File: hw/flash_rw_seq.sv
`include "flash_tester_macros.svh"

module flash_rw_seq
(
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        step,
   input  logic                        start_write,
   input  logic                        start_read,
   input  logic                        erase_done,
   input  logic [`FLASH_DATA_W-1:0]    data_in,
   input  logic [`FLASH_ADDR_W-1:0]    addr_in,
   input  logic [`FLASH_DATA_W-1:0]    frdata,
   output logic                        req,
   output flash_cmd_pkg::flash_op_t    req_op,
   output logic [`FLASH_ADDR_W-1:0]    req_addr,
   output logic [`FLASH_DATA_W-1:0]    req_data,
   output logic [`FLASH_DATA_W-1:0]    rd_data,
   output logic                        done,
   output logic                        err,
   output logic                        phase_valid,
   output tester_pkg::tester_status_t  err_code,
   output tester_pkg::tester_status_t  phase_code
);
   import flash_cmd_pkg::*;
   import tester_pkg::*;

   rw_state_t state;
   rw_state_t next_state;
   logic [`FLASH_ADDR_W-1:0] wptr;    // Next word to program
   logic [`FLASH_ADDR_W-1:0] raddr;
   logic [`FLASH_DATA_W-1:0] wdata;

   assign err_code = STATUS_WRITE_ERROR;

   always_comb
   begin
      req         = 1'b0;
      req_op      = FLASHOP_IDLE;
      req_addr    = wptr;
      req_data    = wdata;
      done        = 1'b0;
      err         = 1'b0;
      phase_valid = 1'b0;
      phase_code  = STATUS_WRITING;
      next_state  = state;
      if (step)
      begin
         case (state)
            RW_IDLE:
               if (start_write)
               begin
                  req         = 1'b1;
                  req_op      = FLASHOP_WRITE;
                  req_data    = CMD_WRITE_SETUP;
                  phase_valid = 1'b1;
                  next_state  = RW_WRITE_DATA;
               end
               else if (start_read)
               begin
                  req         = 1'b1;   // Read array mode before every read
                  req_op      = FLASHOP_WRITE;
                  req_addr    = '0;
                  req_data    = CMD_READ_ARRAY;
                  phase_valid = 1'b1;
                  phase_code  = STATUS_READING;
                  next_state  = RW_READ;
               end
            RW_WRITE_DATA:
            begin
               req        = 1'b1;
               req_op     = FLASHOP_WRITE;
               next_state = RW_POLL_RD;
            end
            RW_POLL_RD:
            begin
               req        = 1'b1;
               req_op     = FLASHOP_READ;
               next_state = RW_POLL_CHK;
            end
            RW_POLL_CHK:
               if (!frdata[7])
               begin
                  req    = 1'b1;   // Program still running
                  req_op = FLASHOP_READ;
               end
               else
               begin
                  err        = (|frdata[6:1]) || (wptr == `FLASH_LAST_ADDRESS);
                  done       = !err;
                  next_state = RW_IDLE;
               end
            RW_READ:
            begin
               req        = 1'b1;
               req_op     = FLASHOP_READ;
               req_addr   = raddr;
               next_state = RW_CAPTURE;
            end
            RW_CAPTURE:
            begin
               done       = 1'b1;
               next_state = RW_IDLE;
            end
            default:
               next_state = RW_IDLE;
         endcase
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state <= RW_IDLE;
         wptr  <= '0;
      end
      else
      begin
         state <= next_state;
         if (erase_done)
            wptr <= '0;
         else if (done && (state == RW_POLL_CHK))
            wptr <= wptr + 1'b1;
      end
   end

   always_ff @(posedge clock)
   begin
      if (start_write)
         wdata <= data_in;
      if (start_read)
         raddr <= addr_in;
      if (done && (state == RW_CAPTURE))
         rd_data <= frdata;   // Word from the read at raddr
   end

endmodule

// File: hw/flash_mode_ctrl.sv
module flash_mode_ctrl
(
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        step,
   input  tester_pkg::host_mode_t      mode,
   output logic                        busy,
   output tester_pkg::tester_status_t  status,
   output logic                        start_init,
   output logic                        start_write,
   output logic                        start_read,
   input  logic                        seq_done,
   input  logic                        seq_err,
   input  tester_pkg::tester_status_t  err_code,
   input  tester_pkg::tester_status_t  phase_code,
   input  logic                        phase_valid
);
   import tester_pkg::*;

   typedef enum logic [1:0]
   {
      CTRL_HOME,
      CTRL_INIT,
      CTRL_RW,
      CTRL_HALT
   } ctrl_state_t;

   ctrl_state_t state;
   logic at_home;

   assign at_home     = step && (state == CTRL_HOME);
   assign start_init  = at_home && (mode == MODE_INIT);
   assign start_write = at_home && (mode == MODE_WRITE);
   assign start_read  = at_home && (mode == MODE_READ);

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state  <= CTRL_HOME;
         busy   <= 1'b1;
         status <= STATUS_RESET;
      end
      else
      begin
         if (phase_valid)
            status <= phase_code;
         case (state)
            CTRL_HOME:
               if (step)
               begin
                  busy <= (mode != MODE_IDLE);   // Falls only on an idle mode
                  if (mode == MODE_INIT)
                     state <= CTRL_INIT;
                  else if (mode != MODE_IDLE)
                     state <= CTRL_RW;
               end
            CTRL_INIT, CTRL_RW:
               if (seq_err)
               begin
                  status <= err_code;
                  state  <= CTRL_HALT;
               end
               else if (seq_done)
               begin
                  if (state == CTRL_INIT)
                     status <= STATUS_SUCCESS;
                  state <= CTRL_HOME;
               end
            default:
               busy <= 1'b1;   // Halted until reset
         endcase
      end
   end

endmodule

// File: hw/flash_tester_top.sv
`include "flash_tester_macros.svh"

module flash_tester_top
(
   input  logic                        clock,
   input  logic                        reset,
   input  tester_pkg::host_mode_t      mode,
   input  logic [`FLASH_DATA_W-1:0]    data_in,
   input  logic [`FLASH_ADDR_W-1:0]    addr_in,
   output logic                        busy,
   output tester_pkg::tester_status_t  status,
   output logic [`FLASH_DATA_W-1:0]    rd_data,
   output flash_cmd_pkg::flash_op_t    fop,
   output logic [`FLASH_ADDR_W-1:0]    faddress,
   output logic [`FLASH_DATA_W-1:0]    fwdata,
   input  logic [`FLASH_DATA_W-1:0]    frdata,
   input  logic                        fbusy
);
   import flash_cmd_pkg::*;
   import tester_pkg::*;

   logic step;
   logic start_init;
   logic start_write;
   logic start_read;
   logic seq_done;
   logic seq_err;
   logic phase_valid;
   tester_status_t err_code;
   tester_status_t phase_code;

   logic erase_req;
   flash_op_t erase_op;
   logic [`FLASH_ADDR_W-1:0] erase_addr;
   logic [`FLASH_DATA_W-1:0] erase_data;
   logic erase_seq_done;
   logic erase_err;
   logic wptr_clear;
   logic erase_phase_valid;
   tester_status_t erase_err_code;
   tester_status_t erase_phase_code;

   logic rw_req;
   flash_op_t rw_op;
   logic [`FLASH_ADDR_W-1:0] rw_addr;
   logic [`FLASH_DATA_W-1:0] rw_data;
   logic rw_done;
   logic rw_err;
   logic rw_phase_valid;
   tester_status_t rw_err_code;
   tester_status_t rw_phase_code;

   ////////////////////////////////////////////////////////////
   // Sequencer results toward the controller
   ////////////////////////////////////////////////////////////

   // Only one sequencer runs at a time
   assign seq_done    = erase_seq_done | rw_done;
   assign seq_err     = erase_err | rw_err;
   assign err_code    = erase_err ? erase_err_code : rw_err_code;
   assign phase_valid = erase_phase_valid | rw_phase_valid;
   assign phase_code  = erase_phase_valid ? erase_phase_code : rw_phase_code;

   flash_mode_ctrl mode_ctrl_inst
   (
      .clock(clock), .reset(reset), .step(step), .mode(mode), .busy(busy),
      .status(status), .start_init(start_init), .start_write(start_write),
      .start_read(start_read), .seq_done(seq_done), .seq_err(seq_err),
      .err_code(err_code), .phase_code(phase_code), .phase_valid(phase_valid)
   );

   flash_erase_seq erase_seq_inst
   (
      .clock(clock), .reset(reset), .step(step), .start(start_init),
      .frdata(frdata), .req(erase_req), .req_op(erase_op), .req_addr(erase_addr),
      .req_data(erase_data), .done(erase_seq_done), .err(erase_err),
      .erase_done(wptr_clear), .phase_valid(erase_phase_valid),
      .err_code(erase_err_code), .phase_code(erase_phase_code)
   );

   flash_rw_seq rw_seq_inst
   (
      .clock(clock), .reset(reset), .step(step), .start_write(start_write),
      .start_read(start_read), .erase_done(wptr_clear), .data_in(data_in),
      .addr_in(addr_in), .frdata(frdata), .req(rw_req), .req_op(rw_op),
      .req_addr(rw_addr), .req_data(rw_data), .rd_data(rd_data), .done(rw_done),
      .err(rw_err), .phase_valid(rw_phase_valid), .err_code(rw_err_code),
      .phase_code(rw_phase_code)
   );

   flash_op_port op_port_inst
   (
      .clock(clock), .reset(reset), .fbusy(fbusy), .erase_req(erase_req),
      .rw_req(rw_req), .erase_op(erase_op), .rw_op(rw_op),
      .erase_addr(erase_addr), .rw_addr(rw_addr), .erase_data(erase_data),
      .rw_data(rw_data), .fop(fop), .faddress(faddress), .fwdata(fwdata),
      .step(step)
   );

endmodule

// File: verification/flash_model.sv
`include "flash_tester_macros.svh"

module flash_model
(
   input  logic                        clock,
   input  logic                        reset,
   input  flash_cmd_pkg::flash_op_t    fop,
   input  logic [`FLASH_ADDR_W-1:0]    faddress,
   input  logic [`FLASH_DATA_W-1:0]    fwdata,
   output logic [`FLASH_DATA_W-1:0]    frdata,
   output logic                        fbusy,
   input  logic                        bad_manufacturer,   // Return a wrong ID word
   input  logic                        write_fault         // Program error in status
);
   import flash_cmd_pkg::*;

   typedef enum logic [1:0] {RD_ARRAY, RD_ID, RD_STATUS} read_mode_t;

   logic [`FLASH_DATA_W-1:0] mem [logic [`FLASH_ADDR_W-1:0]];   // Unwritten reads as FFFF
   read_mode_t read_mode;
   logic [`FLASH_DATA_W-1:0] pending;   // First cycle of a two cycle command
   logic [7:0] sr;
   int poll_wait;                       // Status reads that still show busy
   int busy_left;
   int erase_count;
   logic [`FLASH_ADDR_W-1:0] last_wr_addr;
   logic [`FLASH_DATA_W-1:0] last_wr_data;

   task automatic erase_block(input logic [`FLASH_ADDR_W-1:0] addr);
      logic [`FLASH_ADDR_W-1:0] doomed[$];
      foreach (mem[k])
         if ((k / `FLASH_BLOCK_SIZE) == (addr / `FLASH_BLOCK_SIZE))
            doomed.push_back(k);
      foreach (doomed[i])
         mem.delete(doomed[i]);
      erase_count++;
   endtask

   task automatic enter_status(input logic [7:0] value);
      read_mode = RD_STATUS;
      sr        = value;
      poll_wait = $urandom % 3;
      pending   = '0;
   endtask

   always @(posedge clock)
   begin
      if (reset)
      begin
         fbusy       <= 1'b0;
         frdata      <= '0;
         read_mode   = RD_ARRAY;
         pending     = '0;
         busy_left   = 0;
         erase_count = 0;
      end
      else if (fop != FLASHOP_IDLE)
      begin
         busy_left = $urandom_range(4, 1) - 1;
         fbusy    <= 1'b1;
         if (fop == FLASHOP_WRITE)
         begin
            if (pending == CMD_WRITE_SETUP)
            begin
               mem[faddress] = fwdata;
               last_wr_addr  = faddress;
               last_wr_data  = fwdata;
               enter_status(write_fault ? 8'h90 : 8'h80);
            end
            else if ((pending == CMD_ERASE_BLOCK) && (fwdata == CMD_CONFIRM))
            begin
               erase_block(faddress);
               enter_status(8'h80);
            end
            else if ((pending == CMD_CLEAR_LOCKS) && (fwdata == CMD_CONFIRM))
               enter_status(8'h80);
            else if (fwdata == CMD_READ_ID)
               read_mode = RD_ID;
            else if (fwdata == CMD_READ_ARRAY)
               read_mode = RD_ARRAY;
            else
               pending = fwdata;   // Setup word, wait for second cycle
         end
         else
         begin
            case (read_mode)
               RD_ARRAY: frdata <= mem.exists(faddress) ? mem[faddress] : 16'hFFFF;
               RD_ID:
                  if (faddress == '0)
                     frdata <= bad_manufacturer ? 16'h00B0 : FLASH_MANUFACTURER_ID;
                  else
                     frdata <= FLASH_SIZE_ID;
               default:
                  if (poll_wait > 0)
                  begin
                     poll_wait = poll_wait - 1;
                     frdata   <= 16'h0000;   // Still busy
                  end
                  else
                     frdata <= {8'h00, sr};
            endcase
         end
      end
      else if (fbusy)
      begin
         if (busy_left == 0)
            fbusy <= 1'b0;
         else
            busy_left = busy_left - 1;
      end
   end

endmodule

// File: verification/flash_tester_assertions.sv
module flash_tester_assertions
(
   input  logic                        clock,
   input  logic                        reset,
   input  flash_cmd_pkg::flash_op_t    fop,
   input  logic                        fbusy,
   input  logic                        busy
);
   import flash_cmd_pkg::*;

   // Operation strobe is a single cycle
   fop_single_cycle: assert property (@(posedge clock) disable iff (reset)
      (fop != FLASHOP_IDLE) |=> (fop == FLASHOP_IDLE))
      else $error("fop held longer than one cycle");

   fop_not_when_busy: assert property (@(posedge clock) disable iff (reset)
      (fop != FLASHOP_IDLE) |-> !fbusy)
      else $error("fop issued while flash busy");

   busy_after_reset: assert property (@(posedge clock) reset |=> busy)
      else $error("busy low right after reset");

endmodule

bind flash_tester_top flash_tester_assertions flash_tester_assertions_inst
(
   .clock(clock), .reset(reset), .fop(fop), .fbusy(fbusy), .busy(busy)
);

// File: verification/flash_tester_tb.sv
`include "flash_tester_macros.svh"

module flash_tester_tb;
   import flash_cmd_pkg::*;
   import tester_pkg::*;

   // Ten blocks of a few dozen cycles each, with wide margin
   localparam int TIMEOUT_CYCLES = 200000;

   logic clock;
   logic reset;
   host_mode_t mode;
   logic [`FLASH_DATA_W-1:0] data_in;
   logic [`FLASH_ADDR_W-1:0] addr_in;
   logic busy;
   tester_status_t status;
   logic [`FLASH_DATA_W-1:0] rd_data;
   flash_op_t fop;
   logic [`FLASH_ADDR_W-1:0] faddress;
   logic [`FLASH_DATA_W-1:0] fwdata;
   logic [`FLASH_DATA_W-1:0] frdata;
   logic fbusy;
   logic bad_manufacturer;
   logic write_fault;

   int cycles = 0;
   int error_count = 0;
   int check_count = 0;
   logic [`FLASH_DATA_W-1:0] written_mem [logic [`FLASH_ADDR_W-1:0]];

   // Expected result handed to the compare process
   logic result_pending = 1'b0;
   tester_status_t exp_status;
   logic exp_busy;
   logic exp_word_valid;
   logic [`FLASH_DATA_W-1:0] exp_word;

   flash_tester_top flash_tester_top_inst
   (
      .clock(clock), .reset(reset), .mode(mode), .data_in(data_in), .addr_in(addr_in),
      .busy(busy), .status(status), .rd_data(rd_data), .fop(fop), .faddress(faddress),
      .fwdata(fwdata), .frdata(frdata), .fbusy(fbusy)
   );

   flash_model flash_model_inst
   (
      .clock(clock), .reset(reset), .fop(fop), .faddress(faddress), .fwdata(fwdata),
      .frdata(frdata), .fbusy(fbusy), .bad_manufacturer(bad_manufacturer),
      .write_fault(write_fault)
   );

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   function automatic logic [`FLASH_DATA_W-1:0] ref_read(input logic [`FLASH_ADDR_W-1:0] a);
      if (written_mem.exists(a))
         return written_mem[a];
      return 16'hFFFF;   // Erased word
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input logic [`FLASH_DATA_W-1:0] act,
                             input logic [`FLASH_DATA_W-1:0] exp);
      check_count++;
      if (act !== exp)
      begin
         error_count++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
      end
   endtask

   task automatic check_status(input string name, input tester_status_t act,
                               input tester_status_t exp);
      check_count++;
      if (act !== exp)
      begin
         error_count++;
         $display("mismatch at %0t: %s is %s, expected %s", $time, name, act.name(),
                  exp.name());
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      check_count++;
      if (act !== exp)
      begin
         error_count++;
         $display("mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
      end
   endtask

   task automatic check_number(input string name, input int act, input int exp);
      check_count++;
      if (act != exp)
      begin
         error_count++;
         $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      end
   endtask

   always @(posedge clock)
   begin
      if (result_pending)
      begin
         check_status("status", status, exp_status);
         check_flag("busy", busy, exp_busy);
         if (exp_word_valid)
            check_word("rd_data", rd_data, exp_word);
         result_pending = 1'b0;
      end
   end

   always @(posedge clock)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the controller did not finish within %0d cycles", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   task automatic apply_reset();
      @(posedge clock);
      reset <= 1'b1;
      @(posedge clock);
      @(negedge clock);
      check_flag("busy", busy, 1'b1);
      check_status("status", status, STATUS_RESET);
      @(posedge clock);
      reset <= 1'b0;
   endtask

   // Mode handshake that ends when busy falls or the controller halts
   task automatic run_op(input host_mode_t m, input logic [`FLASH_DATA_W-1:0] d,
                         input logic [`FLASH_ADDR_W-1:0] a);
      do @(negedge clock); while (busy);
      @(posedge clock);
      mode    <= m;
      data_in <= d;
      addr_in <= a;
      do @(negedge clock); while (!busy);
      @(posedge clock);
      mode <= MODE_IDLE;
      do @(negedge clock); while (busy && (status < STATUS_BAD_MANUFACTURER));
   endtask

   task automatic expect_result(input tester_status_t st, input logic b, input logic wv,
                                input logic [`FLASH_DATA_W-1:0] w);
      exp_status     = st;
      exp_busy       = b;
      exp_word_valid = wv;
      exp_word       = w;
      result_pending = 1'b1;
      while (result_pending)
         @(negedge clock);
   endtask

   initial
   begin
      logic [31:0] r;
      logic [`FLASH_ADDR_W-1:0] a;
      reset            = 1'b1;
      mode             = MODE_IDLE;
      data_in          = '0;
      addr_in          = '0;
      bad_manufacturer = 1'b0;
      write_fault      = 1'b0;
      void'($urandom(32'h75e85320));
      apply_reset();

      run_op(MODE_INIT, '0, '0);
      expect_result(STATUS_SUCCESS, 1'b0, 1'b0, '0);
      check_number("erase count", flash_model_inst.erase_count, `FLASH_ERASE_BLOCKS);
      written_mem.delete();

      for (int i = 0; i < 20; i++)
      begin
         r = $urandom;
         run_op(MODE_WRITE, r[15:0], '0);
         expect_result(STATUS_WRITING, 1'b0, 1'b0, '0);
         check_number("model write address", int'(flash_model_inst.last_wr_addr), i);
         check_word("model write data", flash_model_inst.last_wr_data, r[15:0]);
         written_mem[i] = r[15:0];
      end

      for (int i = 0; i < 10; i++)
      begin
         r = $urandom;
         a = (i % 2 == 0) ? `FLASH_ADDR_W'(r % 20) : r[`FLASH_ADDR_W-1:0];
         run_op(MODE_READ, '0, a);
         expect_result(STATUS_READING, 1'b0, 1'b1, ref_read(a));
      end

      // Wrong ID halts init, reset brings the controller back
      @(posedge clock);
      bad_manufacturer <= 1'b1;
      apply_reset();
      run_op(MODE_INIT, '0, '0);
      expect_result(STATUS_BAD_MANUFACTURER, 1'b1, 1'b0, '0);
      @(posedge clock);
      bad_manufacturer <= 1'b0;
      apply_reset();
      run_op(MODE_INIT, '0, '0);
      expect_result(STATUS_SUCCESS, 1'b0, 1'b0, '0);
      written_mem.delete();

      @(posedge clock);
      write_fault <= 1'b1;
      r = $urandom;
      run_op(MODE_WRITE, r[15:0], '0);
      expect_result(STATUS_WRITE_ERROR, 1'b1, 1'b0, '0);

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+hw
hw/flash_cmd_pkg.sv
hw/tester_pkg.sv
hw/flash_op_port.sv
hw/flash_erase_seq.sv
hw/flash_rw_seq.sv
hw/flash_mode_ctrl.sv
hw/flash_tester_top.sv
verification/flash_model.sv
verification/flash_tester_assertions.sv
verification/flash_tester_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the flash tester simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module flash_tester_tb \
   -f filelist.f -o flash_tester_sim
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

out=$(./obj_dir/flash_tester_sim)
run_status=$?
echo "$out"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

echo "$out" | grep -qx ">>> PASS" || exit 1
exit 0
